// File: design/fifo_macros.svh
// FIFO build constants
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

//--------------------------------------------------------------------------
// storage geometry
//--------------------------------------------------------------------------
// number of entries, power of two
`define FIFO_DEPTH 16

// word width seen at the FIFO ports
`define DATA_WIDTH 16

// width of one RAM slice, DATA_WIDTH is a multiple of it
`define SLICE_WIDTH 4

//--------------------------------------------------------------------------
// fill-level alert
//--------------------------------------------------------------------------
// alert raised at and above this count
`define ALERT_LEVEL 8

`endif

// File: design/fifoPkg.sv
// FIFO shared types
`include "fifo_macros.svh"

package fifoPkg;

	// pointer width from depth
	localparam int addrWidth = $clog2(`FIFO_DEPTH);

	//----------------------------------------------------------------------
	// pointer and level types
	//----------------------------------------------------------------------
	// write/read pointer, also the RAM address
	typedef logic [addrWidth-1:0] addrT;

	// fill count, wrapped pointer difference
	typedef logic [addrWidth-1:0] countT;

	//----------------------------------------------------------------------
	// payload
	//----------------------------------------------------------------------
	// one FIFO word
	typedef logic [`DATA_WIDTH-1:0] dataT;

endpackage

// File: design/ramPortIf.sv
// RAM slice port bundle
`timescale 1ns/1ps
`include "fifo_macros.svh"

interface ramPortIf #(
	// bits carried by one slice
	parameter int sliceWidth = `SLICE_WIDTH
);

	// write port
	logic [sliceWidth-1:0] wd;
	fifoPkg::addrT wa;
	logic we;

	// read port
	fifoPkg::addrT ra;
	logic re;
	logic [sliceWidth-1:0] rd;

	// controller side, drives addresses and strobes
	modport ctrl (
		output wd,
		output wa,
		output we,
		output ra,
		output re,
		input rd
	);

	// RAM side, returns read data
	modport ram (
		input wd,
		input wa,
		input we,
		input ra,
		input re,
		output rd
	);

endinterface

// File: design/sdpRamSlice.sv
// simple dual-port RAM slice
`timescale 1ns/1ps
`include "fifo_macros.svh"

module sdpRamSlice #(
	// must match the width of the connected bundle
	parameter int sliceWidth = `SLICE_WIDTH
)(
	input logic iCLK,
	ramPortIf.ram port
);

	//----------------------------------------------------------------------
	// storage array
	//----------------------------------------------------------------------
	// one word per FIFO entry, block RAM style
	logic [sliceWidth-1:0] mem [`FIFO_DEPTH];

	//----------------------------------------------------------------------
	// write port
	//----------------------------------------------------------------------
	// synchronous write on strobe
	always_ff @(posedge iCLK)
	begin
		if (port.we)
		begin
			mem[port.wa] <= port.wd;
		end
	end

	//----------------------------------------------------------------------
	// read port
	//----------------------------------------------------------------------
	// registered output, held between accepted reads
	always_ff @(posedge iCLK)
	begin
		if (port.re)
		begin
			port.rd <= mem[port.ra];
		end
	end

endmodule

// File: design/syncFifoController.sv
// synchronous FIFO controller
// pointers, flags and sliced storage
`timescale 1ns/1ps
`include "fifo_macros.svh"

module syncFifoController #(
	// fill level that raises the alert
	parameter int alertLevel = `ALERT_LEVEL
)(
	input logic iCLK,
	input logic inARST,
	// write side
	input fifoPkg::dataT wd,
	input logic we,
	// read side
	input logic re,
	// status
	output logic full,
	output logic emp,
	output logic remainAlert,
	// read data
	output logic rvd,
	output fifoPkg::dataT rd
);

	// slice geometry
	localparam int sliceWidth = `SLICE_WIDTH;
	localparam int sliceCount = `DATA_WIDTH / `SLICE_WIDTH;

	//----------------------------------------------------------------------
	// pointers and qualified strobes
	//----------------------------------------------------------------------
	fifoPkg::addrT wa;
	fifoPkg::addrT ra;
	fifoPkg::addrT waNext;
	fifoPkg::addrT raNext;

	// raw strobes gated by the flags
	logic weOk;
	logic reOk;

	// next pointer values, wrap naturally at depth
	assign waNext = fifoPkg::addrT'(wa + 1'b1);
	assign raNext = fifoPkg::addrT'(ra + 1'b1);

	// write dropped while full, read dropped while empty
	assign weOk = we & ~full;
	assign reOk = re & ~emp;

	// write pointer
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			wa <= '0;
		end
		else if (weOk)
		begin
			wa <= waNext;
		end
	end

	// read pointer
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			ra <= '0;
		end
		else if (reOk)
		begin
			ra <= raNext;
		end
	end

	// valid strobe, one cycle behind the accepted read
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			rvd <= 1'b0;
		end
		else
		begin
			rvd <= reOk;
		end
	end

	//----------------------------------------------------------------------
	// flags
	//----------------------------------------------------------------------
	// one slot kept free so full and empty differ
	assign full = (waNext == ra);
	assign emp = (wa == ra);

	//----------------------------------------------------------------------
	// fill-level alert
	//----------------------------------------------------------------------
	fifoPkg::countT fillCount;

	// modulo-depth difference of the pointers
	assign fillCount = fifoPkg::countT'(wa - ra);

	// high while at or above the threshold
	assign remainAlert = (fillCount >= fifoPkg::countT'(alertLevel));

	//----------------------------------------------------------------------
	// sliced storage
	//----------------------------------------------------------------------
	// word split into slice-sized lanes, lane 0 is the LSBs
	logic [sliceCount-1:0][sliceWidth-1:0] sliceWd;
	logic [sliceCount-1:0][sliceWidth-1:0] sliceRd;

	assign sliceWd = wd;

	genvar g;
	generate
		for (g = 0; g < sliceCount; g++)
		begin : ramLane
			// port bundle for this lane
			ramPortIf #(
				.sliceWidth(sliceWidth)
			) ramBus ();

			// all lanes share addresses and strobes
			assign ramBus.wd = sliceWd[g];
			assign ramBus.wa = wa;
			assign ramBus.we = weOk;
			assign ramBus.ra = ra;
			assign ramBus.re = reOk;

			sdpRamSlice #(
				.sliceWidth(sliceWidth)
			) ramSlice (
				.iCLK(iCLK),
				.port(ramBus.ram)
			);

			// lane output back into the word
			assign sliceRd[g] = ramBus.rd;
		end
	endgenerate

	// reassembled read word
	assign rd = fifoPkg::dataT'(sliceRd);

endmodule

// File: design/fifoTop.sv
// FIFO top level
`timescale 1ns/1ps
`include "fifo_macros.svh"

module fifoTop #(
	// alert threshold passed to the controller
	parameter int alertLevel = `ALERT_LEVEL
)(
	input logic iCLK,
	input logic inARST,
	// write side
	input fifoPkg::dataT wd,
	input logic we,
	// read side
	input logic re,
	// status
	output logic full,
	output logic emp,
	output logic remainAlert,
	// read data
	output logic rvd,
	output fifoPkg::dataT rd
);

	//----------------------------------------------------------------------
	// controller outputs
	//----------------------------------------------------------------------
	logic fullW;
	logic empW;
	logic alertW;
	logic rvdW;
	fifoPkg::dataT rdW;

	//----------------------------------------------------------------------
	// FIFO controller with sliced RAM
	//----------------------------------------------------------------------
	syncFifoController #(
		.alertLevel(alertLevel)
	) fifoCtrl (
		.iCLK(iCLK),
		.inARST(inARST),
		.wd(wd),
		.we(we),
		.re(re),
		.full(fullW),
		.emp(empW),
		.remainAlert(alertW),
		.rvd(rvdW),
		.rd(rdW)
	);

	// status and data out
	assign full = fullW;
	assign emp = empW;
	assign remainAlert = alertW;
	assign rvd = rvdW;
	assign rd = rdW;

endmodule

// File: bench/clkGen.sv
// testbench clock and reset source
`timescale 1ns/1ps

module clkGen #(
	// half of the 20 ns period
	parameter int halfPeriod = 10,
	// cycles spent in reset
	parameter int resetCycles = 10
)(
	output logic iCLK,
	output logic inARST
);

	//----------------------------------------------------------------------
	// free-running clock
	//----------------------------------------------------------------------
	initial
	begin
		iCLK = 1'b0;
		forever
		begin
			#halfPeriod iCLK = ~iCLK;
		end
	end

	//----------------------------------------------------------------------
	// reset, active low
	//----------------------------------------------------------------------
	// released on a falling edge, away from the sampling edge
	initial
	begin
		inARST = 1'b0;
		repeat (resetCycles) @(negedge iCLK);
		inARST = 1'b1;
	end

endmodule

// File: bench/tbTop.sv
// trace-driven FIFO testbench
`timescale 1ns/1ps
`include "fifo_macros.svh"

module tbTop;

	//----------------------------------------------------------------------
	// DUT connections
	//----------------------------------------------------------------------
	logic iCLK;
	logic inARST;
	fifoPkg::dataT wd;
	logic we;
	logic re;
	logic full;
	logic emp;
	logic remainAlert;
	logic rvd;
	fifoPkg::dataT rd;

	//----------------------------------------------------------------------
	// trace contents with one entry per cycle
	//----------------------------------------------------------------------
	// stimulus columns
	logic weQ[$];
	fifoPkg::dataT wdQ[$];
	logic reQ[$];
	// expected columns
	logic empQ[$];
	logic fullQ[$];
	logic alertQ[$];
	logic rvdQ[$];
	fifoPkg::dataT rdQ[$];

	// run limit stays zero until the trace is loaded
	int cycleCount = 0;
	int cycleLimit = 0;

	//----------------------------------------------------------------------
	// clock, reset and DUT
	//----------------------------------------------------------------------
	clkGen clockSource (
		.iCLK(iCLK),
		.inARST(inARST)
	);

	fifoTop dut (
		.iCLK(iCLK),
		.inARST(inARST),
		.wd(wd),
		.we(we),
		.re(re),
		.full(full),
		.emp(emp),
		.remainAlert(remainAlert),
		.rvd(rvd),
		.rd(rd)
	);

	//----------------------------------------------------------------------
	// failure handling
	//----------------------------------------------------------------------
	// final words of a failed run
	task automatic endInFailure();
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	// compare one observed value with its expected value
	task automatic check(
		input string name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected)
		begin
			$display("Fail at %0d ns: %s expected %0h, got %0h",
				$time, name, expected, actual);
			endInFailure();
		end
	endtask

	//----------------------------------------------------------------------
	// trace reader
	//----------------------------------------------------------------------
	// lines starting with # are comments
	task automatic loadTrace();
		int fd;
		int code;
		int fields;
		string line;
		logic [31:0] weV;
		logic [31:0] wdV;
		logic [31:0] reV;
		logic [31:0] empV;
		logic [31:0] fullV;
		logic [31:0] alertV;
		logic [31:0] rvdV;
		logic [31:0] rdV;

		fd = $fopen("bench/fifoTrace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file bench/fifoTrace.txt");
			endInFailure();
		end
		else
		begin
			code = $fgets(line, fd);
			while (code > 0)
			begin
				// skip blank lines and lines starting with # (8'h23)
				if (line.len() > 1 && line.getc(0) != 8'h23)
				begin
					fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
						weV, wdV, reV, empV, fullV, alertV, rvdV, rdV);
					if (fields != 8)
					begin
						$display("trace line has %0d fields instead of 8: %s",
							fields, line);
						endInFailure();
					end
					else
					begin
						weQ.push_back(weV[0]);
						wdQ.push_back(wdV[`DATA_WIDTH-1:0]);
						reQ.push_back(reV[0]);
						empQ.push_back(empV[0]);
						fullQ.push_back(fullV[0]);
						alertQ.push_back(alertV[0]);
						rvdQ.push_back(rvdV[0]);
						rdQ.push_back(rdV[`DATA_WIDTH-1:0]);
					end
				end
				code = $fgets(line, fd);
			end
			$fclose(fd);
		end
	endtask

	//----------------------------------------------------------------------
	// timeout watchdog
	//----------------------------------------------------------------------
	// reset time fits inside the 20 spare cycles
	always @(posedge iCLK)
	begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
		begin
			$display("timeout, trace not finished after %0d cycles", cycleLimit);
			endInFailure();
		end
	end

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial
	begin
		// quiet inputs through reset
		we = 1'b0;
		re = 1'b0;
		wd = '0;

		loadTrace();
		if (weQ.size() == 0)
		begin
			$display("trace file holds no cycles");
			endInFailure();
		end
		cycleLimit = weQ.size() + 20;

		wait (inARST === 1'b1);

		for (int i = 0; i < weQ.size(); i++)
		begin
			// outputs settled since the last rising edge
			@(negedge iCLK);
			check("emp", 32'(empQ[i]), 32'(emp));
			check("full", 32'(fullQ[i]), 32'(full));
			check("remainAlert", 32'(alertQ[i]), 32'(remainAlert));
			check("rvd", 32'(rvdQ[i]), 32'(rvd));
			// read data only meaningful with the strobe
			if (rvdQ[i])
			begin
				check("rd", 32'(rdQ[i]), 32'(rd));
			end

			// this cycle's requests
			we = weQ[i];
			wd = wdQ[i];
			re = reQ[i];
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: project.f
+incdir+design
design/fifoPkg.sv
design/ramPortIf.sv
design/sdpRamSlice.sv
design/syncFifoController.sv
design/fifoTop.sv
bench/clkGen.sv
bench/tbTop.sv

// File: run.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator.
# The exit status is the simulator's, so a failed run fails the script.

set -e

# work from the project root so relative paths in project.f resolve
cd "$(dirname "$0")"

# compile the bench and DUT into one executable
verilator --binary --timing \
	-f project.f \
	--top-module tbTop \
	--Mdir obj_dir \
	-o tbSim

# run the simulation, which reads bench/fifoTrace.txt
./obj_dir/tbSim

// File: bench/fifoTrace.txt
# columns: we wd re, then expected emp full remainAlert rvd rd (all hex)
# expected values are sampled before the line's own requests take effect
# read while empty, then idle
0 0000 1 1 0 0 0 0000
0 0000 0 1 0 0 0 0000
# fifteen writes, alert from the eighth entry
1 3a7c 0 1 0 0 0 0000
1 91e5 0 0 0 0 0 0000
1 0b48 0 0 0 0 0 0000
1 c2d1 0 0 0 0 0 0000
1 5f09 0 0 0 0 0 0000
1 e6a3 0 0 0 0 0 0000
1 1d7e 0 0 0 0 0 0000
1 8840 0 0 0 0 0 0000
1 47bc 0 0 0 1 0 0000
1 b315 0 0 0 1 0 0000
1 6ef2 0 0 0 1 0 0000
1 2c98 0 0 0 1 0 0000
1 f05d 0 0 0 1 0 0000
1 7a61 0 0 0 1 0 0000
1 d4c7 0 0 0 1 0 0000
# write while full is dropped
1 9b2e 0 0 1 1 0 0000
0 0000 0 0 1 1 0 0000
# drain in write order
0 0000 1 0 1 1 0 0000
0 0000 1 0 0 1 1 3a7c
0 0000 1 0 0 1 1 91e5
0 0000 1 0 0 1 1 0b48
0 0000 1 0 0 1 1 c2d1
0 0000 1 0 0 1 1 5f09
0 0000 1 0 0 1 1 e6a3
0 0000 1 0 0 1 1 1d7e
0 0000 1 0 0 0 1 8840
0 0000 1 0 0 0 1 47bc
0 0000 1 0 0 0 1 b315
0 0000 1 0 0 0 1 6ef2
0 0000 1 0 0 0 1 2c98
0 0000 1 0 0 0 1 f05d
0 0000 1 0 0 0 1 7a61
0 0000 1 1 0 0 1 d4c7
# refill across the pointer wrap
1 05f3 0 1 0 0 0 0000
1 ca6b 0 0 0 0 0 0000
1 63d0 0 0 0 0 0 0000
1 1e8f 0 0 0 0 0 0000
# simultaneous write and read, count holds at four
1 a942 1 0 0 0 0 0000
1 7c15 1 0 0 0 1 05f3
1 e0b8 1 0 0 0 1 ca6b
1 3346 1 0 0 0 1 63d0
1 bd7a 1 0 0 0 1 1e8f
1 5821 1 0 0 0 1 a942
# final drain
0 0000 1 0 0 0 1 7c15
0 0000 1 0 0 0 1 e0b8
0 0000 1 0 0 0 1 3346
0 0000 1 0 0 0 1 bd7a
0 0000 0 1 0 0 1 5821
0 0000 0 1 0 0 0 0000
